// File: iotdf_pkg.sv
package iotdf_pkg;

  // stream and block geometry
  localparam int BYTE_W           = 8;
  localparam int BLOCK_W          = 128;
  localparam int BYTES_PER_BLOCK  = 16;
  localparam int BLOCKS_PER_GROUP = 8;

  // crc remainder width and generator x^3+x^2+x with its leading bit
  localparam int          CRC_W    = 3;
  localparam logic [3:0]  CRC_POLY = 4'b1110;

  // an input byte from the host
  typedef logic [BYTE_W-1:0]  byte_t;

  // a data block, also used for every result word
  typedef logic [BLOCK_W-1:0] block_t;

  // crc remainder
  typedef logic [CRC_W-1:0]   crc_t;

  // byte lane inside a block
  typedef logic [3:0]         byte_idx_t;

  // block slot inside a group of eight
  typedef logic [2:0]         block_idx_t;

  // function codes as sent by the host
  // codes 1 and 2 and every other unused code fall into idle
  typedef enum logic [2:0] {
    FN_NONE     = 3'd0,
    FN_CRC_GEN  = 3'd3,
    FN_TOP2MAX  = 3'd4,
    FN_LAST2MIN = 3'd5
  } fn_sel_t;

endpackage

// File: byte_loader.sv
`timescale 1ns/1ps

module byte_loader (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_in_en,
  input  iotdf_pkg::byte_t  i_iot_in,
  output iotdf_pkg::block_t o_block,
  output logic              o_block_valid
);

  import iotdf_pkg::*;

  byte_idx_t byte_cnt;
  block_t    block_q;
  logic      last_byte;
  logic      block_valid_q;

  // the 16th byte of a block is on the bus
  assign last_byte = i_in_en && (byte_cnt == byte_idx_t'(BYTES_PER_BLOCK - 1));

  // lane counter wraps after the last lane
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      byte_cnt <= '0;
    end else if (i_in_en) begin
      byte_cnt <= byte_cnt + 1'b1;
    end
  end

  // byte k lands in bits 8k+7 down to 8k
  always_ff @(posedge i_clk) begin
    if (i_in_en) begin
      block_q[byte_cnt*BYTE_W +: BYTE_W] <= i_iot_in;
    end
  end

  // one cycle flag once the block register is complete
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      block_valid_q <= 1'b0;
    end else begin
      block_valid_q <= last_byte;
    end
  end

  // lane 0 of the next block is only written after the flag cycle,
  // so the block is whole while the flag is high
  assign o_block       = block_q;
  assign o_block_valid = block_valid_q;

endmodule

// File: crc3_engine.sv
`timescale 1ns/1ps

module crc3_engine (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_start,
  input  iotdf_pkg::block_t i_block,
  output iotdf_pkg::crc_t   o_crc,
  output logic              o_done
);

  import iotdf_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_CALC
  } state_t;

  state_t                      state;
  logic [BLOCK_W+CRC_W-1:0]    dividend;
  logic [BLOCK_W+CRC_W-1:0]    dividend_sub;
  logic [6:0]                  step_cnt;
  logic                        last_step;
  logic                        done_q;

  // subtract the generator at the top when the leading bit is set
  always_comb begin
    dividend_sub = dividend;
    if (dividend[BLOCK_W+CRC_W-1]) begin
      dividend_sub = dividend ^ {CRC_POLY, {(BLOCK_W-1){1'b0}}};
    end
  end

  assign last_step = (state == S_CALC) && (step_cnt == 7'(BLOCK_W - 1));

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state    <= S_IDLE;
      step_cnt <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= last_step;
      case (state)
        S_IDLE: begin
          step_cnt <= '0;
          if (i_start) begin
            state <= S_CALC;
          end
        end
        S_CALC: begin
          step_cnt <= step_cnt + 1'b1;
          if (last_step) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // block with three zero bits appended, then one division step per cycle
  always_ff @(posedge i_clk) begin
    if (state == S_IDLE && i_start) begin
      dividend <= {i_block, {CRC_W{1'b0}}};
    end else if (state == S_CALC) begin
      dividend <= {dividend_sub[BLOCK_W+CRC_W-2:0], 1'b0};
    end
  end

  // after 128 steps the remainder sits in the top bits
  assign o_crc  = dividend[BLOCK_W+CRC_W-1 -: CRC_W];
  assign o_done = done_q;

endmodule

// File: extreme_tracker.sv
`timescale 1ns/1ps

module extreme_tracker (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_start,
  input  logic              i_find_max,
  input  iotdf_pkg::block_t i_block,
  output iotdf_pkg::block_t o_result,
  output logic              o_valid
);

  import iotdf_pkg::*;

  typedef enum logic [1:0] {
    S_COLLECT,
    S_EMIT_FIRST,
    S_EMIT_SECOND
  } state_t;

  state_t     state;
  block_idx_t blk_cnt;
  block_t     first_q;
  block_t     second_q;
  logic       beats_first;
  logic       beats_second;
  logic       group_end;

  // strict compare in the direction of the selected function
  function automatic logic is_better(input block_t cand, input block_t ref_val,
                                     input logic find_max);
    logic res;
    if (find_max) begin
      res = cand > ref_val;
    end else begin
      res = cand < ref_val;
    end
    return res;
  endfunction

  assign beats_first  = is_better(i_block, first_q, i_find_max);
  assign beats_second = is_better(i_block, second_q, i_find_max);
  assign group_end    = i_start && (blk_cnt == block_idx_t'(BLOCKS_PER_GROUP - 1));

  // group position and result sequencing
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state   <= S_COLLECT;
      blk_cnt <= '0;
    end else begin
      if (i_start) begin
        blk_cnt <= blk_cnt + 1'b1;
      end
      case (state)
        S_COLLECT: begin
          if (group_end) begin
            state <= S_EMIT_FIRST;
          end
        end
        S_EMIT_FIRST:  state <= S_EMIT_SECOND;
        S_EMIT_SECOND: state <= S_COLLECT;
        default:       state <= S_COLLECT;
      endcase
    end
  end

  // best and runner-up of the current group
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      if (blk_cnt == '0) begin
        first_q  <= i_block;
        // neutral runner-up so any later block can take its place
        second_q <= i_find_max ? '0 : '1;
      end else if (beats_first) begin
        first_q  <= i_block;
        second_q <= first_q;
      end else if (beats_second) begin
        second_q <= i_block;
      end
    end
  end

  assign o_valid  = (state == S_EMIT_FIRST) || (state == S_EMIT_SECOND);
  assign o_result = (state == S_EMIT_SECOND) ? second_q : first_q;

endmodule

// File: iotdf_ctrl.sv
`timescale 1ns/1ps

module iotdf_ctrl (
  input  logic                i_clk,
  input  logic                i_rst,
  input  iotdf_pkg::fn_sel_t  i_fn_sel,
  input  logic                i_block_valid,
  input  iotdf_pkg::crc_t     i_crc,
  input  logic                i_crc_done,
  input  iotdf_pkg::block_t   i_ext_result,
  input  logic                i_ext_valid,
  output logic                o_crc_start,
  output logic                o_ext_start,
  output logic                o_find_max,
  output logic                o_busy,
  output logic                o_valid,
  output iotdf_pkg::block_t   o_iot_out
);

  import iotdf_pkg::*;

  logic   crc_mode;
  logic   ext_mode;
  logic   busy_q;
  logic   valid_q;
  logic   crc_hit;
  logic   ext_hit;
  block_t out_q;

  // decode the function and leave every other code idle
  assign crc_mode   = (i_fn_sel == FN_CRC_GEN);
  assign ext_mode   = (i_fn_sel == FN_TOP2MAX) || (i_fn_sel == FN_LAST2MIN);
  assign o_find_max = (i_fn_sel == FN_TOP2MAX);

  // block pulses go to the selected engine only
  assign o_crc_start = crc_mode && i_block_valid;
  assign o_ext_start = ext_mode && i_block_valid;

  assign crc_hit = crc_mode && i_crc_done;
  assign ext_hit = ext_mode && i_ext_valid;

  // busy held from the crc start until the result has left
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      busy_q <= 1'b0;
    end else if (o_crc_start) begin
      busy_q <= 1'b1;
    end else if (valid_q) begin
      busy_q <= 1'b0;
    end
  end

  // busy shows up in the same cycle as the block pulse
  assign o_busy = busy_q || o_crc_start;

  // output stage adds one cycle after the engine result
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      valid_q <= 1'b0;
      out_q   <= '0;
    end else begin
      valid_q <= crc_hit || ext_hit;
      if (crc_hit) begin
        out_q <= {{(BLOCK_W-CRC_W){1'b0}}, i_crc};
      end else if (ext_hit) begin
        out_q <= i_ext_result;
      end
    end
  end

  assign o_valid   = valid_q;
  assign o_iot_out = out_q;

endmodule

// File: iotdf_top.sv
`timescale 1ns/1ps

module iotdf_top (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_in_en,
  input  iotdf_pkg::byte_t    i_iot_in,
  input  iotdf_pkg::fn_sel_t  i_fn_sel,
  output logic                o_busy,
  output logic                o_valid,
  output iotdf_pkg::block_t   o_iot_out
);

  import iotdf_pkg::*;

  block_t block;
  logic   block_valid;
  logic   crc_start;
  logic   ext_start;
  logic   find_max;
  crc_t   crc;
  logic   crc_done;
  block_t ext_result;
  logic   ext_valid;

  // byte stream front end
  byte_loader u_byte_loader (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_in_en       (i_in_en),
    .i_iot_in      (i_iot_in),
    .o_block       (block),
    .o_block_valid (block_valid)
  );

  crc3_engine u_crc3_engine (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (crc_start),
    .i_block (block),
    .o_crc   (crc),
    .o_done  (crc_done)
  );

  extreme_tracker u_extreme_tracker (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (ext_start),
    .i_find_max (find_max),
    .i_block    (block),
    .o_result   (ext_result),
    .o_valid    (ext_valid)
  );

  // function decode, busy and result register
  iotdf_ctrl u_iotdf_ctrl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_fn_sel      (i_fn_sel),
    .i_block_valid (block_valid),
    .i_crc         (crc),
    .i_crc_done    (crc_done),
    .i_ext_result  (ext_result),
    .i_ext_valid   (ext_valid),
    .o_crc_start   (crc_start),
    .o_ext_start   (ext_start),
    .o_find_max    (find_max),
    .o_busy        (o_busy),
    .o_valid       (o_valid),
    .o_iot_out     (o_iot_out)
  );

endmodule

// File: tb_iotdf.sv
`timescale 1ns/1ps

module tb_iotdf;

  import iotdf_pkg::*;

  logic    i_clk;
  logic    i_rst;
  logic    i_in_en;
  byte_t   i_iot_in;
  fn_sel_t i_fn_sel;
  logic    o_busy;
  logic    o_valid;
  block_t  o_iot_out;

  integer  seed;
  int      errors;
  int      checks;
  longint  cycle;
  logic    busy_forbidden;
  block_t  grp [0:7];
  block_t  obs_val [$];
  longint  obs_cyc [$];
  block_t  exp_val [$];
  bit      dup_grp [$];

  iotdf_top i_dut (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in_en   (i_in_en),
    .i_iot_in  (i_iot_in),
    .i_fn_sel  (i_fn_sel),
    .o_busy    (o_busy),
    .o_valid   (o_valid),
    .o_iot_out (o_iot_out)
  );

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle = cycle + 1;
  end

  // capture results at the falling edge where outputs are stable
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_valid) begin
        obs_val.push_back(o_iot_out);
        obs_cyc.push_back(cycle);
      end
      if (busy_forbidden) begin
        checks++;
        assert (o_busy === 1'b0) else begin
          errors++;
          $display("ERROR: o_busy got 0x%h expected 0x0", o_busy);
        end
      end
    end
  end

  task finish_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task abort_run(input string what);
    errors++;
    $display("timeout: %s", what);
    finish_run();
  endtask

  task check_value(input string name, input block_t got, input block_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return r % n;
  endfunction

  function automatic block_t random_block();
    block_t b;
    int     k;
    for (k = 0; k < BYTES_PER_BLOCK; k++) begin
      b[k*BYTE_W +: BYTE_W] = BYTE_W'($random(seed));
    end
    return b;
  endfunction

  // long division of block*x^3 by the generator
  function automatic crc_t crc_model(input block_t blk);
    logic [BLOCK_W+CRC_W-1:0] rem;
    int                       i;
    rem = {blk, {CRC_W{1'b0}}};
    for (i = BLOCK_W + CRC_W - 1; i >= CRC_W; i--) begin
      if (rem[i]) begin
        rem[i -: 4] = rem[i -: 4] ^ CRC_POLY;
      end
    end
    return rem[CRC_W-1:0];
  endfunction

  function automatic logic ranks_above(input block_t a, input block_t b, input logic find_max);
    return find_max ? (a > b) : (a < b);
  endfunction

  task best_index(input logic find_max, output int idx);
    int j;
    idx = 0;
    for (j = 1; j < BLOCKS_PER_GROUP; j++) begin
      if (ranks_above(grp[j], grp[idx], find_max)) begin
        idx = j;
      end
    end
  endtask

  // runner-up is the best of the seven left after dropping one copy of the best
  task group_extremes(input logic find_max, output block_t best, output block_t runner);
    int bi;
    int j;
    bit have;
    best_index(find_max, bi);
    best   = grp[bi];
    runner = '0;
    have   = 1'b0;
    for (j = 0; j < BLOCKS_PER_GROUP; j++) begin
      if (j != bi && (!have || ranks_above(grp[j], runner, find_max))) begin
        runner = grp[j];
        have   = 1'b1;
      end
    end
  endtask

  task apply_reset(input fn_sel_t fn);
    @(negedge i_clk);
    i_rst    = 1'b1;
    i_in_en  = 1'b0;
    i_iot_in = '0;
    i_fn_sel = fn;
    repeat (8) @(negedge i_clk);
    i_rst = 1'b0;
    obs_val.delete();
    obs_cyc.delete();
    exp_val.delete();
    dup_grp.delete();
    @(negedge i_clk);
    check_value("o_busy", o_busy, 0);
    check_value("o_valid", o_valid, 0);
    check_value("o_iot_out", o_iot_out, 0);
  endtask

  // random idle gaps between bytes but none after the last byte
  task send_block(input block_t blk, input int max_gap);
    int k;
    for (k = 0; k < BYTES_PER_BLOCK; k++) begin
      if (k > 0 && max_gap > 0) begin
        repeat (rand_below(max_gap + 1)) @(negedge i_clk);
      end
      i_in_en  = 1'b1;
      i_iot_in = blk[k*BYTE_W +: BYTE_W];
      @(negedge i_clk);
      i_in_en  = 1'b0;
    end
  endtask

  task wait_busy_low(input int limit);
    int n;
    n = 0;
    while (o_busy && n < limit) begin
      @(negedge i_clk);
      n++;
    end
    if (o_busy) begin
      abort_run("o_busy stayed high");
    end
  endtask

  task wait_valid(input int limit);
    int n;
    n = 0;
    while (!o_valid && n < limit) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_valid) begin
      abort_run("no CRC result arrived");
    end
  endtask

  task wait_results(input int count, input int limit);
    int n;
    n = 0;
    while (obs_val.size() < count && n < limit) begin
      @(negedge i_clk);
      n++;
    end
    if (obs_val.size() < count) begin
      abort_run("extremes results missing");
    end
  endtask

  task run_crc_phase();
    int     b;
    block_t blk;
    crc_t   exp_crc;
    apply_reset(FN_CRC_GEN);
    for (b = 0; b < 20; b++) begin
      blk     = random_block();
      exp_crc = crc_model(blk);
      wait_busy_low(20);
      send_block(blk, 1);
      check_value("o_busy", o_busy, 1);
      wait_valid(200);
      check_value("o_iot_out", o_iot_out, {{(BLOCK_W-CRC_W){1'b0}}, exp_crc});
      @(negedge i_clk);
      // a single pulse with busy released right after it
      check_value("o_valid", o_valid, 0);
      check_value("o_busy", o_busy, 0);
      repeat (rand_below(3)) @(negedge i_clk);
    end
    checks++;
    assert (obs_val.size() == 20) else begin
      errors++;
      $display("CRC mode gave %0d result pulses instead of 20", obs_val.size());
    end
  endtask

  // groups 6 and 7 carry the best value twice
  task run_ext_phase(input fn_sel_t fn, input logic find_max);
    int     g;
    int     b;
    int     bi;
    int     k;
    block_t best;
    block_t runner;
    apply_reset(fn);
    busy_forbidden = 1'b1;
    for (g = 0; g < 8; g++) begin
      for (b = 0; b < BLOCKS_PER_GROUP; b++) begin
        grp[b] = random_block();
      end
      if (g >= 6) begin
        best_index(find_max, bi);
        k      = (bi + 1 + rand_below(7)) % BLOCKS_PER_GROUP;
        grp[k] = grp[bi];
      end
      group_extremes(find_max, best, runner);
      exp_val.push_back(best);
      exp_val.push_back(runner);
      dup_grp.push_back(g >= 6);
      for (b = 0; b < BLOCKS_PER_GROUP; b++) begin
        send_block(grp[b], 2);
        repeat (rand_below(3)) @(negedge i_clk);
      end
    end
    wait_results(16, 50);
    repeat (4) @(negedge i_clk);
    busy_forbidden = 1'b0;
    checks++;
    assert (obs_val.size() == 16) else begin
      errors++;
      $display("extremes mode gave %0d result words instead of 16", obs_val.size());
    end
    for (k = 0; k < 16; k++) begin
      check_value("o_iot_out", obs_val[k], exp_val[k]);
    end
    for (g = 0; g < 8; g++) begin
      checks++;
      assert (obs_cyc[2*g+1] == obs_cyc[2*g] + 1) else begin
        errors++;
        $display("results of group %0d were not on consecutive cycles", g);
      end
      if (dup_grp[g]) begin
        check_value("o_iot_out runner-up", obs_val[2*g+1], exp_val[2*g]);
      end
    end
  endtask

  // codes 0, 1 and 2 share 32 blocks
  task run_idle_phase();
    int c;
    int b;
    int n;
    for (c = 0; c < 3; c++) begin
      apply_reset(fn_sel_t'(c));
      busy_forbidden = 1'b1;
      for (b = 0; b < ((c == 2) ? 10 : 11); b++) begin
        send_block(random_block(), 1);
      end
      n = 0;
      while (n < 300) begin
        @(negedge i_clk);
        n++;
      end
      busy_forbidden = 1'b0;
      checks++;
      assert (obs_val.size() == 0) else begin
        errors++;
        $display("o_valid rose under idle function code %0d", c);
      end
    end
  endtask

  initial begin
    i_clk          = 1'b0;
    i_rst          = 1'b1;
    i_in_en        = 1'b0;
    i_iot_in       = '0;
    i_fn_sel       = FN_NONE;
    seed           = 32'h7aac;
    errors         = 0;
    checks         = 0;
    cycle          = 0;
    busy_forbidden = 1'b0;
    run_crc_phase();
    run_ext_phase(FN_TOP2MAX, 1'b1);
    run_ext_phase(FN_LAST2MIN, 1'b0);
    run_idle_phase();
    finish_run();
  end

endmodule

// File: project.f
iotdf_pkg.sv
byte_loader.sv
crc3_engine.sv
extreme_tracker.sv
iotdf_ctrl.sv
iotdf_top.sv
tb_iotdf.sv

// File: Bender.yml
package:
  name: iotdf

sources:
  - iotdf_pkg.sv
  - byte_loader.sv
  - crc3_engine.sv
  - extreme_tracker.sv
  - iotdf_ctrl.sv
  - iotdf_top.sv
  - target: test
    files:
      - tb_iotdf.sv
